// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_pipeline
FILELIST  := vlog.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== decode_stage.sv ====
`timescale 1ns/100ps

// field split, load-use check, id/ex register
module decode_stage import pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  ctrl_vec_t stall_i,
  input  ctrl_vec_t flush_i,
  input  stage_t    if_id_i,
  output stage_t    id_ex_o,
  output logic      load_use_valid_o
);

  stage_t   id_ex_q;
  reg_idx_t id_rs1;      // sources of the word in id
  reg_idx_t id_rs2;
  reg_idx_t ex_rd;       // dest of the word one ahead
  logic     ex_is_load;
  logic     src_match;

  assign id_rs1 = instr_rs1(if_id_i.instr);
  assign id_rs2 = instr_rs2(if_id_i.instr);
  assign ex_rd  = instr_rd(id_ex_q.instr);

  assign ex_is_load = id_ex_q.valid && (instr_op(id_ex_q.instr) == op_load);
  assign src_match  = (ex_rd == id_rs1) || (ex_rd == id_rs2);

  // load result not ready for the next word, so one bubble is needed
  assign load_use_valid_o = ex_is_load && if_id_i.valid && src_match;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex_q.valid <= 1'b0;
    end else begin
      id_ex_q <= stage_step(id_ex_q, if_id_i, stall_i[STG_ID_EX], flush_i[STG_ID_EX]);
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/100ps

// jump resolve, mul/div timing, ex/mem register
module execute_stage import pipe_pkg::*; #(
  parameter int unsigned MULDIV_CYCLES = 4  // 2 or more
) (
  input  logic      clk,
  input  logic      rst,
  input  ctrl_vec_t stall_i,
  input  ctrl_vec_t flush_i,
  input  stage_t    id_ex_i,
  output stage_t    ex_mem_o,
  output logic      jump_valid_o,
  output pc_t       jump_target_o,
  output logic      mul_div_valid_o
);

  localparam int CNT_W = $clog2(MULDIV_CYCLES);

  stage_t           ex_mem_q;
  op_e              ex_op;
  logic             is_muldiv;
  logic             last_cycle;  // final mul/div cycle, let it go
  logic [CNT_W-1:0] cnt_q;       // cycles spent in id/ex so far

  assign ex_op      = instr_op(id_ex_i.instr);
  assign is_muldiv  = id_ex_i.valid && (ex_op == op_muldiv);
  assign last_cycle = (cnt_q == CNT_W'(MULDIV_CYCLES - 1));

  // counter restarts whenever id/ex takes new contents
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (!stall_i[STG_ID_EX]) begin
      cnt_q <= '0;
    end else if (is_muldiv && !last_cycle) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign mul_div_valid_o = is_muldiv && !last_cycle;

  // jumps always taken
  assign jump_valid_o  = id_ex_i.valid && (ex_op == op_jump);
  assign jump_target_o = instr_target(id_ex_i.instr);

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem_q.valid <= 1'b0;
    end else begin
      ex_mem_q <= stage_step(ex_mem_q, id_ex_i, stall_i[STG_EX_MEM],
                             flush_i[STG_EX_MEM]);
    end
  end

  assign ex_mem_o = ex_mem_q;

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/100ps

// pc register plus if/id
module fetch_stage import pipe_pkg::*; #(
  parameter pc_t TRAP_VEC = 8'h80
) (
  input  logic      clk,
  input  logic      rst,
  input  ctrl_vec_t stall_i,
  input  ctrl_vec_t flush_i,
  input  logic      jump_valid_i,   // redirect from ex
  input  pc_t       jump_target_i,
  input  logic      trap_valid_i,   // redirect from wb
  input  instr_t    instr_i,        // imem word for pc_o
  output pc_t       pc_o,
  output stage_t    if_id_o
);

  pc_t    pc_q;
  stage_t if_d;     // candidate for if/id
  stage_t if_id_q;

  assign if_d = '{valid: 1'b1, pc: pc_q, instr: instr_i};

  // trap beats jump beats sequential
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else if (!stall_i[STG_PC]) begin
      if (trap_valid_i) begin
        pc_q <= TRAP_VEC;
      end else if (jump_valid_i) begin
        pc_q <= jump_target_i;
      end else begin
        pc_q <= pc_q + pc_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if_id_q.valid <= 1'b0;  // only valid needs clearing
    end else begin
      if_id_q <= stage_step(if_id_q, if_d, stall_i[STG_IF_ID], flush_i[STG_IF_ID]);
    end
  end

  assign pc_o    = pc_q;
  assign if_id_o = if_id_q;

endmodule

// ==== mem_wb_stage.sv ====
`timescale 1ns/100ps

// mem ram wait, mem/wb register, retirement
module mem_wb_stage import pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  ctrl_vec_t stall_i,
  input  ctrl_vec_t flush_i,
  input  stage_t    ex_mem_i,
  input  logic      mem_ram_busy_i,
  output logic      ram_stall_valid_o,
  output logic      trap_valid_o,
  output logic      retire_valid_o,
  output pc_t       retire_pc_o
);

  stage_t mem_wb_q;
  logic   mem_is_load;  // load sitting in ex/mem
  logic   wb_is_trap;

  assign mem_is_load = ex_mem_i.valid && (instr_op(ex_mem_i.instr) == op_load);

  // only loads touch the data ram
  assign ram_stall_valid_o = mem_is_load && mem_ram_busy_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_q.valid <= 1'b0;
    end else begin
      mem_wb_q <= stage_step(mem_wb_q, ex_mem_i, stall_i[STG_MEM_WB],
                             flush_i[STG_MEM_WB]);
    end
  end

  assign wb_is_trap = instr_op(mem_wb_q.instr) == op_trap;

  // commit point
  assign retire_valid_o = mem_wb_q.valid && !stall_i[STG_WB];
  assign retire_pc_o    = mem_wb_q.pc;

  // from the entry alone, keeps the path out of the stall vector
  assign trap_valid_o = mem_wb_q.valid && wb_is_trap;

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

  typedef logic [7:0]  pc_t;        // instruction address
  typedef logic [2:0]  reg_idx_t;   // register index
  typedef logic [19:0] instr_t;     // op | rd | rs1 | rs2 | target
  typedef logic [5:0]  ctrl_vec_t;  // stall / flush, one bit per register

  typedef enum logic [2:0] {
    op_alu    = 3'd0,
    op_load   = 3'd1,
    op_jump   = 3'd2,
    op_muldiv = 3'd3,
    op_trap   = 3'd4
  } op_e;

  // bit positions inside ctrl_vec_t
  localparam int STG_PC     = 0;
  localparam int STG_IF_ID  = 1;
  localparam int STG_ID_EX  = 2;
  localparam int STG_EX_MEM = 3;
  localparam int STG_MEM_WB = 4;
  localparam int STG_WB     = 5;  // commit of the mem/wb entry

  typedef struct packed {
    logic   valid;  // 0 means bubble
    pc_t    pc;
    instr_t instr;
  } stage_t;

  // field extraction, top down
  function automatic op_e instr_op(instr_t w);
    return op_e'(w[19:17]);
  endfunction

  function automatic reg_idx_t instr_rd(instr_t w);
    return w[16:14];
  endfunction

  function automatic reg_idx_t instr_rs1(instr_t w);
    return w[13:11];
  endfunction

  function automatic reg_idx_t instr_rs2(instr_t w);
    return w[10:8];
  endfunction

  function automatic pc_t instr_target(instr_t w);
    return w[7:0];
  endfunction

  // one pipe register step: stall holds, flush drops a bubble, else take nxt
  function automatic stage_t stage_step(stage_t cur, stage_t nxt,
                                        logic stall, logic flush);
    stage_t r;
    r = nxt;
    if (stall) begin
      r = cur;
    end else if (flush) begin
      r.valid = 1'b0;  // payload left as is, never looked at
    end
    return r;
  endfunction

endpackage

// ==== pipeline_control.sv ====
`timescale 1ns/100ps

// hazard ranking, pure combinational
module pipeline_control import pipe_pkg::*; (
  input  logic      ram_stall_valid_if_i,    // if ram busy
  input  logic      ram_stall_valid_mem_i,   // load waiting on mem ram
  input  logic      load_use_valid_id_i,     // load-use from id
  input  logic      jump_valid_ex_i,         // taken jump in ex
  input  logic      alu_mul_div_valid_ex_i,  // mul/div still busy in ex
  input  logic      trap_flush_valid_wb_i,   // trap retiring from wb
  output ctrl_vec_t stall_o,
  output ctrl_vec_t flush_o
);

  // stall / flush pairs, bit order {wb, mem/wb, ex/mem, id/ex, if/id, pc}
  localparam ctrl_vec_t TRAP_STALL     = 6'b000000;
  localparam ctrl_vec_t TRAP_FLUSH     = 6'b011110;  // drop everything younger
  localparam ctrl_vec_t RAM_MEM_STALL  = 6'b001111;  // freeze up to ex/mem
  localparam ctrl_vec_t RAM_MEM_FLUSH  = 6'b010000;  // bubble into mem/wb
  localparam ctrl_vec_t JUMP_STALL     = 6'b000000;
  localparam ctrl_vec_t JUMP_FLUSH     = 6'b000110;  // two wrong-path slots
  localparam ctrl_vec_t MUL_DIV_STALL  = 6'b000111;
  localparam ctrl_vec_t MUL_DIV_FLUSH  = 6'b001000;
  localparam ctrl_vec_t LOAD_USE_STALL = 6'b000011;
  localparam ctrl_vec_t LOAD_USE_FLUSH = 6'b000100;
  localparam ctrl_vec_t RAM_IF_STALL   = 6'b000011;  // hold pc and if/id
  localparam ctrl_vec_t RAM_IF_FLUSH   = 6'b000100;  // id/ex gets a bubble
  localparam ctrl_vec_t NO_HAZARD      = 6'b000000;

  // later stage wins; losers re-raise next cycle
  always_comb begin
    if (trap_flush_valid_wb_i) begin
      stall_o = TRAP_STALL;
      flush_o = TRAP_FLUSH;
    end else if (ram_stall_valid_mem_i) begin
      stall_o = RAM_MEM_STALL;
      flush_o = RAM_MEM_FLUSH;
    end else if (jump_valid_ex_i) begin
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (alu_mul_div_valid_ex_i) begin
      stall_o = MUL_DIV_STALL;
      flush_o = MUL_DIV_FLUSH;
    end else if (load_use_valid_id_i) begin
      stall_o = LOAD_USE_STALL;
      flush_o = LOAD_USE_FLUSH;
    end else if (ram_stall_valid_if_i) begin
      // fetch word not there yet
      stall_o = RAM_IF_STALL;
      flush_o = RAM_IF_FLUSH;
    end else begin
      stall_o = NO_HAZARD;
      flush_o = NO_HAZARD;
    end
  end

endmodule

// ==== pipeline_top.sv ====
`timescale 1ns/100ps

module pipeline_top import pipe_pkg::*; #(
  parameter pc_t         TRAP_VEC      = 8'h80,
  parameter int unsigned MULDIV_CYCLES = 4
) (
  input  logic   clk,
  input  logic   rst,
  input  instr_t instr_i,         // imem word at pc_o
  input  logic   if_ram_busy_i,
  input  logic   mem_ram_busy_i,
  output pc_t    pc_o,
  output logic   retire_valid_o,
  output pc_t    retire_pc_o
);

  ctrl_vec_t stall;
  ctrl_vec_t flush;
  stage_t    if_id;
  stage_t    id_ex;
  stage_t    ex_mem;
  logic      load_use_valid;
  logic      jump_valid;
  pc_t       jump_target;
  logic      mul_div_valid;
  logic      ram_stall_mem;
  logic      trap_valid;

  pipeline_control i_pipeline_control (
    .ram_stall_valid_if_i   (if_ram_busy_i),
    .ram_stall_valid_mem_i  (ram_stall_mem),
    .load_use_valid_id_i    (load_use_valid),
    .jump_valid_ex_i        (jump_valid),
    .alu_mul_div_valid_ex_i (mul_div_valid),
    .trap_flush_valid_wb_i  (trap_valid),
    .stall_o                (stall),
    .flush_o                (flush)
  );

  fetch_stage #(.TRAP_VEC(TRAP_VEC)) i_fetch_stage (
    .clk, .rst, .stall_i(stall), .flush_i(flush),
    .jump_valid_i(jump_valid), .jump_target_i(jump_target),
    .trap_valid_i(trap_valid), .instr_i, .pc_o, .if_id_o(if_id)
  );

  decode_stage i_decode_stage (
    .clk, .rst, .stall_i(stall), .flush_i(flush), .if_id_i(if_id),
    .id_ex_o(id_ex), .load_use_valid_o(load_use_valid)
  );

  execute_stage #(.MULDIV_CYCLES(MULDIV_CYCLES)) i_execute_stage (
    .clk, .rst, .stall_i(stall), .flush_i(flush), .id_ex_i(id_ex),
    .ex_mem_o(ex_mem), .jump_valid_o(jump_valid),
    .jump_target_o(jump_target), .mul_div_valid_o(mul_div_valid)
  );

  mem_wb_stage i_mem_wb_stage (
    .clk, .rst, .stall_i(stall), .flush_i(flush), .ex_mem_i(ex_mem),
    .mem_ram_busy_i, .ram_stall_valid_o(ram_stall_mem),
    .trap_valid_o(trap_valid), .retire_valid_o, .retire_pc_o
  );

endmodule

// ==== tb_pipeline.sv ====
`timescale 1ns/100ps

module tb_pipeline;
  import pipe_pkg::*;

  localparam pc_t TRAP_VEC      = 8'h80;
  localparam int  MULDIV_CYCLES = 4;
  localparam int  CLK_NS        = 4;
  localparam int  RST_CYCLES    = 10;
  localparam int  N_RETIRE      = 200;  // checked retirements per test
  localparam int  N_TESTS       = 6;
  localparam int  WATCHDOG_CYCLES = N_TESTS * (RST_CYCLES + 1 + N_RETIRE * (MULDIV_CYCLES + 8));

  logic   clk;
  logic   rst;
  logic   if_ram_busy;
  logic   mem_ram_busy;
  pc_t    pc;
  logic   retire_valid;
  pc_t    retire_pc;
  instr_t imem_word;
  instr_t prog [256];  // imem contents
  pc_t    exp_pcs [$]; // retirement order from the model
  integer seed;
  int     errors;
  int     n_pass;
  int     n_fail;

  assign imem_word = prog[pc];  // zero-latency imem

  pipeline_top #(.TRAP_VEC(TRAP_VEC), .MULDIV_CYCLES(MULDIV_CYCLES)) i_pipeline_top (
    .clk, .rst, .instr_i(imem_word), .if_ram_busy_i(if_ram_busy),
    .mem_ram_busy_i(mem_ram_busy), .pc_o(pc), .retire_valid_o(retire_valid),
    .retire_pc_o(retire_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // architectural next pc
  function automatic pc_t model_next(pc_t cur, instr_t w);
    case (w[19:17])
      op_jump: return w[7:0];
      op_trap: return TRAP_VEC;
      default: return cur + 8'd1;
    endcase
  endfunction

  // op mix in percent with alu filling the rest
  task automatic gen_program(input int p_load, input int p_jump, input int p_muldiv,
                             input int p_trap);
    logic [31:0] w;
    logic [2:0]  op;
    logic [2:0]  prev_rd;
    logic        prev_load;
    int          r;
    prev_load = 1'b0;
    prev_rd   = '0;
    for (int i = 0; i < 256; i++) begin
      r = {$random(seed)} % 100;
      if (r < p_load) op = op_load;
      else if (r < p_load + p_jump) op = op_jump;
      else if (r < p_load + p_jump + p_muldiv) op = op_muldiv;
      else if (r < p_load + p_jump + p_muldiv + p_trap) op = op_trap;
      else op = op_alu;
      w = $random(seed);
      w[19:17] = op;
      if (prev_load) w[13:11] = prev_rd;  // successor reads the loaded reg
      prog[pc_t'(i)] = w[19:0];
      prev_load = (op == op_load);
      prev_rd   = w[16:14];
    end
  endtask

  task automatic check_pc(input string name, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected pc %0h, actual pc %0h", name, exp, act);
    end
  endtask

  task automatic check_gap(input string name, input int lo, input int hi, input int act);
    if (act < lo || act > hi) begin
      errors++;
      $display("CHECK FAILED %s: expected gap %0d..%0d, actual gap %0d", name, lo, hi, act);
    end
  endtask

  task automatic run_test(input string name, input int id, input logic busy_en);
    pc_t    cur;
    instr_t w;
    int     n_ret;
    int     cyc;
    int     last_cyc;
    int     err0;
    logic   after_trap;
    logic   trap_redirect;
    exp_pcs.delete();
    cur = '0;
    for (int i = 0; i < N_RETIRE; i++) begin
      exp_pcs.push_back(cur);
      cur = model_next(cur, prog[cur]);
    end
    @(posedge clk);
    rst          <= 1'b1;
    if_ram_busy  <= 1'b0;
    mem_ram_busy <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    err0 = errors;
    n_ret = 0;
    cyc = 0;
    last_cyc = 0;
    after_trap = 1'b0;
    trap_redirect = 1'b0;
    while (n_ret < N_RETIRE) begin
      @(posedge clk);
      if (busy_en) begin
        if_ram_busy  <= (($random(seed) & 3) == 0);  // busy about a quarter of cycles
        mem_ram_busy <= (($random(seed) & 3) == 0);
      end
      @(negedge clk);  // outputs settled mid-cycle
      cyc++;
      if (trap_redirect) check_pc(name, TRAP_VEC, pc);  // fetch sits on the trap vector
      trap_redirect = 1'b0;
      if (retire_valid) begin
        w = prog[retire_pc];
        check_pc(name, exp_pcs[n_ret], retire_pc);
        if (id == 1 && n_ret > 0) check_gap(name, 1, 1, cyc - last_cyc);
        if (id == 4 && n_ret > 0 && w[19:17] == op_muldiv)
          check_gap(name, MULDIV_CYCLES, cyc, cyc - last_cyc);
        if (after_trap) check_pc(name, TRAP_VEC, retire_pc);
        after_trap = (w[19:17] == op_trap);
        trap_redirect = after_trap;
        last_cyc = cyc;
        n_ret++;
      end
    end
    if_ram_busy  <= 1'b0;
    mem_ram_busy <= 1'b0;
    if (errors == err0) n_pass++;
    else n_fail++;
    $display("%s: %s, %0d retirements in %0d cycles", name,
             (errors == err0) ? "PASS" : "FAIL", n_ret, cyc);
  endtask

  initial begin
    seed = 32'h9a3b_5475;
    rst = 1'b1;
    if_ram_busy = 1'b0;
    mem_ram_busy = 1'b0;
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    gen_program(0, 0, 0, 0);
    run_test("alu_only", 1, 1'b0);
    gen_program(0, 30, 0, 0);
    run_test("jumps", 2, 1'b0);
    gen_program(40, 0, 0, 0);
    run_test("load_use", 3, 1'b0);
    gen_program(15, 0, 30, 0);
    run_test("muldiv", 4, 1'b0);
    gen_program(20, 10, 10, 5);  // every op class
    run_test("random_busy", 5, 1'b1);
    gen_program(0, 5, 0, 10);
    run_test("traps", 6, 1'b0);
    $display("summary: %0d pass, %0d fail", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // worst case per retirement over all tests
  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
pipe_pkg.sv
pipeline_control.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
pipeline_top.sv
tb_pipeline.sv
